// File: compile.f
+incdir+.
fetch_pkg.sv
fetch_rom.sv
line_cache.sv
fetcher.sv
fetch_top.sv
tb_fetch_top.sv

// File: fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// fetch address width, cache depth is 2**FETCH_ADDR_W
`define FETCH_ADDR_W 4

// one byte per entry
`define FETCH_DATA_W 8

// ROM contents rule: byte(a) = (a * ROM_MUL)[7:0] ^ ROM_XOR
`define ROM_MUL 29
`define ROM_XOR 8'h5A

`endif

// File: fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_W-1:0] fetch_addr_t;
    typedef logic [`FETCH_DATA_W-1:0] fetch_data_t;

    // client request, sampled with req
    typedef struct packed {
        fetch_addr_t addr;
    } fetch_req_t;

    // client response, valid with rsp_valid
    typedef struct packed {
        fetch_data_t data;
        logic        hit;   // served from cache
    } fetch_rsp_t;

    // fetcher to cache
    typedef struct packed {
        logic        cs;    // chip select
        logic        we;    // write when set, read otherwise
        fetch_addr_t addr;
        fetch_data_t wdata;
    } cache_cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_CHECK,
        ST_ROM_READ,
        ST_FILL
    } fetch_state_e;

endpackage

`default_nettype wire

// File: fetch_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_rom
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        en,
    input  fetch_addr_t addr,
    output fetch_data_t data
);

    localparam int DEPTH = 1 << `FETCH_ADDR_W;

    fetch_data_t rom_mem [DEPTH];

    // constant table built from the address rule
    for (genvar a = 0; a < DEPTH; a++) begin : g_word
        localparam int unsigned PRODUCT = a * `ROM_MUL;
        assign rom_mem[a] = fetch_data_t'(PRODUCT) ^ `ROM_XOR;  // low byte only
    end

    // registered read, output holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            data <= rom_mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,         // one-cycle strobe
    input  fetch_req_t req_data,
    input  logic       flush,       // only while busy is low
    output logic       busy,
    output logic       rsp_valid,   // one-cycle pulse
    output fetch_rsp_t rsp
);

    // the fetcher owns ROM and cache, so it is the whole subsystem
    fetcher fetcher_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_data  (req_data),
        .flush     (flush),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// File: fetcher.sv
`timescale 1ns/1ps
`default_nettype none

module fetcher
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  fetch_req_t req_data,
    input  logic       flush,
    output logic       busy,
    output logic       rsp_valid,
    output fetch_rsp_t rsp
);

    fetch_state_e state;
    fetch_addr_t  addr_q;       // latched request address
    logic         cs_q;
    logic         we_q;
    logic         rom_en;
    logic         rsp_valid_q;
    fetch_rsp_t   rsp_q;

    cache_cmd_t   cache_cmd;
    fetch_data_t  cache_rdata;
    logic         cache_rvalid;
    fetch_data_t  rom_data;

    logic         take_req;
    logic         hit_now;

    assign take_req = (state == ST_IDLE) && req;
    assign hit_now  = (state == ST_CHECK) && cache_rvalid;

    // fill data comes straight off the ROM output register
    assign cache_cmd = '{cs: cs_q, we: we_q, addr: addr_q, wdata: rom_data};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            cs_q        <= 1'b0;
            we_q        <= 1'b0;
            rom_en      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            // strobes default low
            cs_q        <= 1'b0;
            we_q        <= 1'b0;
            rom_en      <= 1'b0;
            rsp_valid_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        cs_q  <= 1'b1;      // cache read of the new address
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state <= ST_CHECK;      // cache answers on this edge
                end
                ST_CHECK: begin
                    if (cache_rvalid) begin
                        rsp_valid_q <= 1'b1;
                        state       <= ST_IDLE;
                    end else begin
                        rom_en <= 1'b1;     // miss, go to ROM
                        state  <= ST_ROM_READ;
                    end
                end
                ST_ROM_READ: begin
                    cs_q  <= 1'b1;          // write lands at the end of ST_FILL
                    we_q  <= 1'b1;
                    state <= ST_FILL;
                end
                ST_FILL: begin
                    rsp_valid_q <= 1'b1;
                    state       <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // address and response payload
    always_ff @(posedge clk) begin
        if (take_req) begin
            addr_q <= req_data.addr;
        end
        if (hit_now) begin
            rsp_q <= '{data: cache_rdata, hit: 1'b1};
        end else if (state == ST_FILL) begin
            rsp_q <= '{data: rom_data, hit: 1'b0};
        end
    end

    assign busy      = (state != ST_IDLE);
    assign rsp_valid = rsp_valid_q;
    assign rsp       = rsp_q;

    fetch_rom rom_i (
        .clk  (clk),
        .en   (rom_en),
        .addr (addr_q),
        .data (rom_data)
    );

    line_cache cache_i (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cache_cmd),
        .flush  (flush),            // passes through untouched
        .rdata  (cache_rdata),
        .rvalid (cache_rvalid)
    );

    // one response per request, never back to back
    a_rsp_single: assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid |=> !rsp_valid
    );

    // the cache is written only while filling after a miss
    a_write_in_fill: assert property (
        @(posedge clk) disable iff (rst)
        (cache_cmd.cs && cache_cmd.we) |-> (state == ST_FILL)
    );

endmodule

`default_nettype wire

// File: line_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module line_cache
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cache_cmd_t  cmd,
    input  logic        flush,
    output fetch_data_t rdata,
    output logic        rvalid
);

    localparam int DEPTH = 1 << `FETCH_ADDR_W;

    fetch_data_t      mem [DEPTH];
    logic [DEPTH-1:0] valid;
    logic             do_write;
    logic             do_read;

    assign do_write = cmd.cs && cmd.we;
    assign do_read  = cmd.cs && !cmd.we;

    // valid bits, flush beats a write in the same cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
        end else if (do_write) begin
            valid[cmd.addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write && !flush) begin
            mem[cmd.addr] <= cmd.wdata;
        end
    end

    // read data, only meaningful alongside rvalid
    always_ff @(posedge clk) begin
        if (do_read) begin
            rdata <= mem[cmd.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (do_read) begin
            rvalid <= valid[cmd.addr] && !flush;   // a flushed entry reads as miss
        end
    end

    // client flushes only while the fetcher is idle, so never during a fill
    a_no_flush_on_write: assert property (
        @(posedge clk) disable iff (rst)
        !(flush && do_write)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the fetch subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f compile.f --top-module tb_fetch_top -o tb_fetch_top

./obj_dir/tb_fetch_top

// File: tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int NUM_ROWS    = 18;
    localparam int RAND_COUNT  = 48;
    localparam int CYCLE_LIMIT = (NUM_ROWS + RAND_COUNT) * 8 + 100;
    localparam int DEPTH       = 1 << `FETCH_ADDR_W;

    typedef struct packed {
        logic        is_flush;
        fetch_addr_t addr;
        logic        exp_hit;
    } stim_row_t;

    logic       clk;
    logic       rst;
    logic       req;
    fetch_req_t req_data;
    logic       flush;
    logic       busy;
    logic       rsp_valid;
    fetch_rsp_t rsp;

    stim_row_t        stim [NUM_ROWS];
    logic [DEPTH-1:0] model_valid;      // which entries the cache should hold
    int               seed;
    int               cycle_count = 0;

    fetch_top fetch_top_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_data  (req_data),
        .flush     (flush),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit sized from the test length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display(">>> FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // expected ROM byte straight from the address rule
    function automatic fetch_data_t rom_byte(input fetch_addr_t a);
        logic [31:0] prod;
        prod = 32'(a) * `ROM_MUL;
        return prod[`FETCH_DATA_W-1:0] ^ `ROM_XOR;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic set_row(input int idx, input logic is_flush, input fetch_addr_t a,
                           input logic hit);
        stim[idx] = '{is_flush: is_flush, addr: a, exp_hit: hit};
    endtask

    task automatic load_table();
        // cold reads all miss
        set_row(0,  1'b0, 4'd0,  1'b0);
        set_row(1,  1'b0, 4'd1,  1'b0);
        set_row(2,  1'b0, 4'd2,  1'b0);
        set_row(3,  1'b0, 4'd3,  1'b0);
        // repeats hit
        set_row(4,  1'b0, 4'd0,  1'b1);
        set_row(5,  1'b0, 4'd1,  1'b1);
        set_row(6,  1'b0, 4'd3,  1'b1);
        // flushed entries miss again and refill
        set_row(7,  1'b1, 4'd0,  1'b0);
        set_row(8,  1'b0, 4'd0,  1'b0);
        set_row(9,  1'b0, 4'd1,  1'b0);
        set_row(10, 1'b0, 4'd0,  1'b1);
        set_row(11, 1'b0, 4'd1,  1'b1);
        set_row(12, 1'b0, 4'd2,  1'b0);
        set_row(13, 1'b0, 4'd9,  1'b0);
        set_row(14, 1'b0, 4'd9,  1'b1);
        set_row(15, 1'b0, 4'd15, 1'b0);
        set_row(16, 1'b0, 4'd15, 1'b1);
        set_row(17, 1'b0, 4'd2,  1'b1);
    endtask

    // counts edges from the one that took the request and checks busy
    task automatic wait_response(output int lat);
        lat = 0;
        @(negedge clk);
        while (!rsp_valid) begin
            check_value("busy", 32'(busy), 32'd1);
            lat++;
            @(negedge clk);
        end
        check_value("busy", 32'(busy), 32'd0);  // idle again once answered
    endtask

    task automatic check_response(input fetch_addr_t a, input logic exp_hit, input int lat);
        int exp_lat;
        exp_lat = exp_hit ? 2 : 4;
        check_value("rsp.hit", 32'(rsp.hit), 32'(exp_hit));
        check_value("rsp.data", 32'(rsp.data), 32'(rom_byte(a)));
        check_value("latency", lat, exp_lat);
    endtask

    task automatic do_read(input fetch_addr_t a, input logic exp_hit);
        int lat;
        @(posedge clk);
        req           <= 1'b1;
        req_data.addr <= a;
        @(posedge clk);
        req <= 1'b0;
        wait_response(lat);
        check_response(a, exp_hit, lat);
        model_valid[a] = 1'b1;
    endtask

    task automatic do_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        model_valid = '0;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);  // flush starts no fetch
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    endtask

    // second strobe lands while the fetcher is busy with the first
    task automatic check_ignored_req(input fetch_addr_t first, input fetch_addr_t second);
        int lat;
        logic exp_hit;
        exp_hit = model_valid[first];
        @(posedge clk);
        req           <= 1'b1;
        req_data.addr <= first;
        @(posedge clk);
        req_data.addr <= second;    // req still high
        @(posedge clk);
        req <= 1'b0;
        wait_response(lat);
        check_response(first, exp_hit, lat + 1);   // one edge already spent
        model_valid[first] = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        end
    endtask

    initial begin
        logic [31:0] r;
        fetch_addr_t a;
        seed        = 32'he82c_168d;
        rst        <= 1'b1;
        req        <= 1'b0;
        req_data   <= '0;
        flush      <= 1'b0;
        model_valid = '0;
        load_table();

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (stim[i].is_flush) begin
                do_flush();
            end else begin
                do_read(stim[i].addr, stim[i].exp_hit);
            end
        end

        check_ignored_req(4'd6, 4'd7);
        do_read(4'd7, 1'b0);    // 7 must not have been filled
        do_read(4'd6, 1'b1);

        // random reads with the odd flush
        for (int i = 0; i < RAND_COUNT; i++) begin
            r = $random(seed);
            if (r[3:0] == 4'd0) begin
                do_flush();
            end else begin
                a = fetch_addr_t'(r >> 4);
                do_read(a, model_valid[a]);
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
